// File: flist.f
+incdir+design
+incdir+sim
design/core_pkg.sv
design/decode_if.sv
design/control_unit.sv
design/regfile.sv
design/execute_unit.sv
design/load_store_unit.sv
design/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// File: sim/tb_ref_model.svh
// Architectural state of the instruction-set model
logic [31:0] m_pc;
logic [31:0] m_regs [0:31];
logic [31:0] m_mem [0:DMEM_WORDS-1];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    logic signed [31:0] sx;
    logic [31:0]        sra;
    sx  = x;
    sra = sx >>> y[4:0];
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return (sx < $signed(y)) ? 32'd1 : 32'd0;
        3'd3:    return (x < y) ? 32'd1 : 32'd0;
        3'd4:    return x ^ y;
        3'd5:    return alt ? sra : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

// Executes the instruction at m_pc and reports the store it makes, if any
task automatic model_step(output logic st_valid, output logic [31:0] st_addr,
                          output logic [3:0] st_be, output logic [31:0] st_data);
    logic [31:0] ins;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] next_pc;
    logic [31:0] rd_val;
    logic [31:0] ea;
    logic [31:0] word;
    logic [7:0]  lb;
    logic [15:0] lh;
    logic        wr;
    logic        taken;
    ins     = imem[m_pc[9:2]];
    rs1_v   = m_regs[ins[19:15]];
    rs2_v   = m_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u   = {ins[31:12], 12'h000};
    imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = m_pc + 32'd4;
    rd_val  = '0;
    wr      = 1'b0;
    taken   = 1'b0;
    st_valid = 1'b0;
    st_addr  = '0;
    st_be    = '0;
    st_data  = '0;
    case (ins[6:0])
        7'h33: begin
            wr     = 1'b1;
            rd_val = alu_ref(ins[14:12], ins[30], rs1_v, rs2_v);
        end
        7'h13: begin
            // Only the right shifts look at bit 30
            wr     = 1'b1;
            rd_val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, rs1_v, imm_i);
        end
        7'h37: begin
            wr     = 1'b1;
            rd_val = imm_u;
        end
        7'h17: begin
            wr     = 1'b1;
            rd_val = m_pc + imm_u;
        end
        7'h03: begin
            ea   = rs1_v + imm_i;
            word = m_mem[ea[7:2]];
            lb   = word[8*ea[1:0] +: 8];
            lh   = word[16*ea[1] +: 16];
            wr   = 1'b1;
            case (ins[14:12])
                3'd0:    rd_val = {{24{lb[7]}}, lb};
                3'd1:    rd_val = {{16{lh[15]}}, lh};
                3'd4:    rd_val = {24'h0, lb};
                3'd5:    rd_val = {16'h0, lh};
                default: rd_val = word;
            endcase
        end
        7'h23: begin
            ea       = rs1_v + imm_s;
            st_valid = 1'b1;
            st_addr  = {ea[31:2], 2'b00};
            st_data  = rs2_v << (8 * ea[1:0]);
            case (ins[14:12])
                3'd0:    st_be = 4'b0001 << ea[1:0];
                3'd1:    st_be = 4'b0011 << ea[1:0];
                default: st_be = 4'b1111;
            endcase
            for (int k = 0; k < 4; k++) begin
                if (st_be[k]) begin
                    m_mem[ea[7:2]][8*k +: 8] = st_data[8*k +: 8];
                end
            end
        end
        7'h63: begin
            case (ins[14:12])
                3'd0:    taken = rs1_v == rs2_v;
                3'd1:    taken = rs1_v != rs2_v;
                3'd4:    taken = $signed(rs1_v) < $signed(rs2_v);
                3'd5:    taken = $signed(rs1_v) >= $signed(rs2_v);
                3'd6:    taken = rs1_v < rs2_v;
                3'd7:    taken = rs1_v >= rs2_v;
                default: taken = 1'b0;
            endcase
            if (taken) begin
                next_pc = m_pc + imm_b;
            end
        end
        7'h6F: begin
            wr      = 1'b1;
            rd_val  = m_pc + 32'd4;
            next_pc = m_pc + imm_j;
        end
        7'h67: begin
            wr      = 1'b1;
            rd_val  = m_pc + 32'd4;
            next_pc = (rs1_v + imm_i) & ~32'd1;
        end
        default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        m_regs[ins[11:7]] = rd_val;
    end
    m_pc = next_pc;
endtask

// File: sim/tb_rv_core.sv
`include "core_defs.svh"

module tb_rv_core
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BODY_LEN   = 200;
    localparam int PROG_LEN   = BODY_LEN + 32;
    localparam int DMEM_WORDS = 64;
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] LOOP_PC = 32'((PROG_LEN - 1) * 4);

    logic     clk = 1'b0;
    logic     rst_n;
    logic     i_stall;
    word_t    i_imem_data;
    word_t    i_dmem_rdata;
    word_t    o_imem_addr;
    word_t    o_dmem_addr;
    word_t    o_dmem_wdata;
    byte_en_t o_dmem_be;
    logic     o_dmem_we;
    logic     o_dmem_re;

    logic [31:0] imem [0:PROG_LEN-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] lcg_state;
    logic        pend_we = 1'b0;
    logic [5:0]  pend_idx;
    logic [3:0]  pend_be;
    logic [31:0] pend_data;

    // Both memories answer combinationally
    assign i_imem_data  = imem[o_imem_addr[9:2]];
    assign i_dmem_rdata = dmem[o_dmem_addr[7:2]];

    rv_core i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_stall      (i_stall),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_be    (o_dmem_be),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_re    (o_dmem_re)
    );

    always #2 clk = ~clk;

    `include "tb_ref_model.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // The low bits of the generator cycle quickly so only the upper bits are used
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next() >> 16;
        return int'(r % 32'(n));
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(32));
    endfunction

    function automatic logic [31:0] encode_store(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [12:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else
            report_failure($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic build_program();
        int          cls;
        int          span;
        int          tgt;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] off;
        for (int i = 0; i < BODY_LEN; i++) begin
            cls  = rand_below(10);
            // Forward targets reach at most the start of the dump
            span = (BODY_LEN - i > 8) ? 8 : BODY_LEN - i;
            tgt  = i + 1 + rand_below(span);
            off  = 32'((tgt - i) * 4);
            f3   = 3'(rand_below(8));
            imm  = 12'(lcg_next() >> 8);
            case (cls)
                0, 1: begin
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00;
                    imem[i] = {f7, rand_reg(), rand_reg(), f3, rand_reg(), 7'h33};
                end
                2, 3: begin
                    if (f3 == 3'd1) begin
                        imm[11:5] = 7'h00;
                    end else if (f3 == 3'd5) begin
                        imm[11:5] = (rand_below(2) == 1) ? 7'h20 : 7'h00;
                    end
                    imem[i] = {imm, rand_reg(), f3, rand_reg(), 7'h13};
                end
                4: imem[i] = {20'(lcg_next() >> 4), rand_reg(),
                              (rand_below(2) == 1) ? 7'h37 : 7'h17};
                5: begin
                    case (rand_below(5))
                        0:       f3 = 3'd0;
                        1:       f3 = 3'd1;
                        2:       f3 = 3'd2;
                        3:       f3 = 3'd4;
                        default: f3 = 3'd5;
                    endcase
                    imm = 12'(rand_below(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
                    imem[i] = {imm, 5'd0, f3, rand_reg(), 7'h03};
                end
                6: begin
                    f3  = 3'(rand_below(3));
                    imm = 12'(rand_below(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
                    imem[i] = encode_store(imm, rand_reg(), 5'd0, f3);
                end
                7: begin
                    f3 = 3'(rand_below(6));
                    if (f3 >= 3'd2) begin
                        f3 = f3 + 3'd2;
                    end
                    imem[i] = encode_branch(off[12:0], rand_reg(), rand_reg(), f3);
                end
                8: imem[i] = encode_jal(off[20:0], rand_reg());
                default: imem[i] = {12'(tgt * 4), 5'd0, 3'd0, rand_reg(), 7'h67};
            endcase
        end
        // Register dump followed by a jump to self
        for (int r = 1; r < 32; r++) begin
            imem[BODY_LEN + r - 1] = encode_store(12'(r * 4), 5'(r), 5'd0, 3'd2);
        end
        imem[PROG_LEN - 1] = encode_jal(21'd0, 5'd0);
    endtask

    // Sampled mid-cycle when every DUT output has settled
    task automatic check_cycle();
        logic        st_valid;
        logic [31:0] st_addr;
        logic [3:0]  st_be;
        logic [31:0] st_data;
        logic [31:0] mask;
        logic        load_exp;
        check_value("fetch_pc", m_pc, o_imem_addr);
        load_exp = (imem[m_pc[9:2]][6:0] == 7'h03);
        check_value("load_strobe", 32'(load_exp), 32'(o_dmem_re));
        if (o_dmem_we && !i_stall) begin
            pend_we   = 1'b1;
            pend_idx  = o_dmem_addr[7:2];
            pend_be   = o_dmem_be;
            pend_data = o_dmem_wdata;
        end
        if (!i_stall) begin
            model_step(st_valid, st_addr, st_be, st_data);
            check_value("store_strobe", 32'(st_valid), 32'(o_dmem_we));
            if (st_valid) begin
                mask = lane_mask(st_be);
                check_value("store_addr", st_addr, o_dmem_addr);
                check_value("store_be", 32'(st_be), 32'(o_dmem_be));
                check_value("store_data", st_data & mask, o_dmem_wdata & mask);
            end
        end
    endtask

    task automatic apply_store();
        if (pend_we) begin
            for (int k = 0; k < 4; k++) begin
                if (pend_be[k]) begin
                    dmem[pend_idx][8*k +: 8] = pend_data[8*k +: 8];
                end
            end
            pend_we = 1'b0;
        end
    endtask

    initial begin
        int cycles;
        rst_n     = 1'b0;
        i_stall   = 1'b0;
        lcg_state = 32'd51;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            dmem[w]  = lcg_next();
            m_mem[w] = dmem[w];
        end
        build_program();
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        m_pc = `CORE_RESET_PC;

        repeat (16) begin
            @(posedge clk);
            #1;
            assert (!o_dmem_we && !o_dmem_re) else
                report_failure("Memory strobe was active while reset was asserted");
        end
        rst_n = 1'b1;
        check_value("reset_pc", `CORE_RESET_PC, o_imem_addr);

        cycles = 0;
        while (m_pc != LOOP_PC && cycles < MAX_CYCLES) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            apply_store();
            #1;
            i_stall = (rand_below(4) == 0);
            cycles++;
        end
        assert (m_pc == LOOP_PC) else
            report_failure($sformatf(
                "Timeout: the core did not reach the final loop in %0d cycles", MAX_CYCLES));

        @(negedge clk);
        check_value("loop_pc", LOOP_PC, o_imem_addr);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: design/rv_core.sv
`include "core_defs.svh"

module rv_core
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_stall,
    input  word_t    i_imem_data,
    input  word_t    i_dmem_rdata,
    output word_t    o_imem_addr,
    output word_t    o_dmem_addr,
    output word_t    o_dmem_wdata,
    output byte_en_t o_dmem_be,
    output logic     o_dmem_we,
    output logic     o_dmem_re
);

    word_t   pc;
    word_t   pc_next;
    word_t   pc_plus4;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_result;
    word_t   target;
    word_t   load_data;
    word_t   wb_data;
    logic    branch_taken;
    pc_src_e pc_src;

    decode_if dec ();

    assign pc_plus4 = pc + 32'd4;

    // A stall freezes fetch on the current instruction
    always_comb begin
        if (i_stall) begin
            pc_next = pc;
        end else if (pc_src == PC_SADD) begin
            pc_next = target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_imem_addr = pc;

    control_unit i_control_unit (
        .i_instr        (i_imem_data),
        .i_branch_taken (branch_taken),
        .dec            (dec.ctrl),
        .o_pc_src       (pc_src)
    );

    always_comb begin
        case (dec.wb_src)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            WB_SADD: wb_data = target;
            default: wb_data = alu_result;
        endcase
    end

    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_rs1    (i_imem_data[19:15]),
        .i_rs2    (i_imem_data[24:20]),
        .i_rd     (i_imem_data[11:7]),
        .i_we     (dec.reg_write && !i_stall),
        .i_wdata  (wb_data),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    execute_unit i_execute_unit (
        .dec            (dec.dp),
        .i_instr        (i_imem_data),
        .i_pc           (pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .o_alu_result   (alu_result),
        .o_target       (target),
        .o_branch_taken (branch_taken)
    );

    load_store_unit i_load_store_unit (
        .dec         (dec.dp),
        .i_funct3    (i_imem_data[14:12]),
        .i_addr      (alu_result),
        .i_rs2_data  (rs2_data),
        .i_rdata     (i_dmem_rdata),
        .o_be        (o_dmem_be),
        .o_wdata     (o_dmem_wdata),
        .o_load_data (load_data)
    );

    // Memory sees word addresses, lanes are picked by the byte enables
    assign o_dmem_addr = {alu_result[`CORE_XLEN-1:2], 2'b00};

    // Keep the strobes quiet while the core is held in reset
    assign o_dmem_we = dec.mem_write && rst_n;
    assign o_dmem_re = dec.mem_read && rst_n;

endmodule

// File: design/load_store_unit.sv
module load_store_unit
    import core_pkg::*;
(
    decode_if.dp     dec,
    input  logic [2:0] i_funct3,
    input  word_t    i_addr,
    input  word_t    i_rs2_data,
    input  word_t    i_rdata,
    output byte_en_t o_be,
    output word_t    o_wdata,
    output word_t    o_load_data
);

    logic [1:0] offset;
    word_t      shifted;

    assign offset = i_addr[1:0];

    // Lane mask from access width and low address bits
    always_comb begin
        o_be = '0;
        if (dec.mem_write || dec.mem_read) begin
            case (i_funct3[1:0])
                2'b00:   o_be = byte_en_t'(4'b0001 << offset);
                2'b01:   o_be = offset[1] ? 4'b1100 : 4'b0011;
                default: o_be = 4'b1111;
            endcase
        end
    end

    // Store data copied into every lane, the mask picks the live one
    always_comb begin
        case (i_funct3[1:0])
            2'b00:   o_wdata = {4{i_rs2_data[7:0]}};
            2'b01:   o_wdata = {2{i_rs2_data[15:0]}};
            default: o_wdata = i_rs2_data;
        endcase
    end

    assign shifted = i_rdata >> {offset, 3'b000};

    always_comb begin
        case (i_funct3)
            3'b000:  o_load_data = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  o_load_data = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  o_load_data = {24'b0, shifted[7:0]};
            3'b101:  o_load_data = {16'b0, shifted[15:0]};
            default: o_load_data = i_rdata;
        endcase
    end

endmodule

// File: design/execute_unit.sv
`include "core_defs.svh"

module execute_unit
    import core_pkg::*;
(
    decode_if.dp  dec,
    input  word_t i_instr,
    input  word_t i_pc,
    input  word_t i_rs1_data,
    input  word_t i_rs2_data,
    output word_t o_alu_result,
    output word_t o_target,
    output logic  o_branch_taken
);

    word_t      imm;
    word_t      op_b;
    word_t      sadd_base;
    word_t      sadd_sum;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    always_comb begin
        case (dec.imm_src)
            IMM_I: imm = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_S: imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                          i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U: imm = {i_instr[31:12], 12'b0};
            IMM_J: imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                          i_instr[20], i_instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign op_b  = (dec.alu_src == ALU_SRC_IMM) ? imm : i_rs2_data;
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(i_rs1_data) < $signed(op_b);
    assign lt_unsigned = i_rs1_data < op_b;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    o_alu_result = i_rs1_data + op_b;
            ALU_SUB:    o_alu_result = i_rs1_data - op_b;
            ALU_AND:    o_alu_result = i_rs1_data & op_b;
            ALU_OR:     o_alu_result = i_rs1_data | op_b;
            ALU_XOR:    o_alu_result = i_rs1_data ^ op_b;
            ALU_SLL:    o_alu_result = i_rs1_data << shamt;
            ALU_SRL:    o_alu_result = i_rs1_data >> shamt;
            ALU_SRA:    o_alu_result = word_t'($signed(i_rs1_data) >>> shamt);
            ALU_SLT:    o_alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   o_alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: o_alu_result = op_b;
            default:    o_alu_result = '0;
        endcase
    end

    // Branches always compare the two registers, never the immediate
    always_comb begin
        case (i_instr[14:12])
            3'b000:  o_branch_taken = i_rs1_data == i_rs2_data;
            3'b001:  o_branch_taken = i_rs1_data != i_rs2_data;
            3'b100:  o_branch_taken = $signed(i_rs1_data) < $signed(i_rs2_data);
            3'b101:  o_branch_taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
            3'b110:  o_branch_taken = i_rs1_data < i_rs2_data;
            3'b111:  o_branch_taken = i_rs1_data >= i_rs2_data;
            default: o_branch_taken = 1'b0;
        endcase
    end

    // Second adder for branch, JAL, JALR and AUIPC targets
    assign sadd_base = (dec.sadd_src == SADD_RS1) ? i_rs1_data : i_pc;
    assign sadd_sum  = sadd_base + imm;

    // Only JALR uses the register base, and it drops bit 0
    assign o_target = (dec.sadd_src == SADD_RS1) ? {sadd_sum[`CORE_XLEN-1:1], 1'b0} : sadd_sum;

endmodule

// File: design/regfile.sv
`include "core_defs.svh"

module regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0] i_rs1,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0] i_rs2,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0] i_rd,
    input  logic                              i_we,
    input  logic [`CORE_XLEN-1:0]             i_wdata,
    output logic [`CORE_XLEN-1:0]             o_rdata1,
    output logic [`CORE_XLEN-1:0]             o_rdata2
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: design/control_unit.sv
module control_unit
    import core_pkg::*;
(
    input  word_t         i_instr,
    input  logic          i_branch_taken,
    decode_if.ctrl        dec,
    output pc_src_e       o_pc_src
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       is_branch;
    logic       is_jump;
    alu_op_e    arith_op;

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    // Shared funct3 decode for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Anything not listed below falls through as a no-op
        dec.alu_op    = ALU_ADD;
        dec.imm_src   = IMM_I;
        dec.alu_src   = ALU_SRC_REG;
        dec.wb_src    = WB_ALU;
        dec.sadd_src  = SADD_PC;
        dec.reg_write = 1'b0;
        dec.mem_read  = 1'b0;
        dec.mem_write = 1'b0;
        is_branch     = 1'b0;
        is_jump       = 1'b0;

        case (opcode)
            OPC_OP: begin
                dec.alu_op    = arith_op;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // ADDI never subtracts since funct7 only qualifies shifts here
                dec.alu_op    = (funct3 == 3'b000) ? ALU_ADD : arith_op;
                dec.alu_src   = ALU_SRC_IMM;
                dec.reg_write = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.imm_src   = IMM_U;
                dec.alu_src   = ALU_SRC_IMM;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm_src   = IMM_U;
                dec.wb_src    = WB_SADD;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.alu_src   = ALU_SRC_IMM;
                dec.wb_src    = WB_LOAD;
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            OPC_STORE: begin
                dec.imm_src   = IMM_S;
                dec.alu_src   = ALU_SRC_IMM;
                dec.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm_src = IMM_B;
                is_branch   = 1'b1;
            end
            OPC_JAL: begin
                dec.imm_src   = IMM_J;
                dec.wb_src    = WB_PC4;
                dec.reg_write = 1'b1;
                is_jump       = 1'b1;
            end
            OPC_JALR: begin
                dec.sadd_src  = SADD_RS1;
                dec.wb_src    = WB_PC4;
                dec.reg_write = 1'b1;
                is_jump       = 1'b1;
            end
            default: ;
        endcase
    end

    assign o_pc_src = (is_jump || (is_branch && i_branch_taken)) ? PC_SADD : PC_PLUS4;

endmodule

// File: design/decode_if.sv
interface decode_if
    import core_pkg::*;
();

    alu_op_e   alu_op;
    imm_src_e  imm_src;
    alu_src_e  alu_src;
    wb_src_e   wb_src;
    sadd_src_e sadd_src;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;

    modport ctrl (
        output alu_op, imm_src, alu_src, wb_src, sadd_src,
        output reg_write, mem_read, mem_write
    );

    modport dp (
        input alu_op, imm_src, alu_src, wb_src, sadd_src,
        input reg_write, mem_read, mem_write
    );

endinterface

// File: design/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]             word_t;
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [`CORE_XLEN/8-1:0]           byte_en_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // Immediate layouts of the RV32I formats
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_src_e;

    typedef enum logic {
        ALU_SRC_REG,
        ALU_SRC_IMM
    } alu_src_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_SADD
    } wb_src_e;

    typedef enum logic {
        PC_PLUS4,
        PC_SADD
    } pc_src_e;

    // Base of the second adder
    typedef enum logic {
        SADD_PC,
        SADD_RS1
    } sadd_src_e;

endpackage

// File: design/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width of the core
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif
